//--- list.f
+incdir+bench
rtl/cpuPkg.sv
rtl/registerFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/resultStage.sv
rtl/cpu.sv
bench/cpu_chk.sv
bench/cpuTb.sv

//--- bench/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// In-order reference state
logic [15:0] modelRegs [16];
logic [15:0] modelMem [256];
// Every data access in program order, loads carry no data
memCmdT expQ [$];
int haltAddr;

// Initial data contents, built from all eight address bits
function automatic logic [15:0] fillWord(input logic [7:0] a);
	return {a ^ 8'hc3, ~a};
endfunction

// Exact sum clamped to the signed range, overflow flag on top
function automatic logic [16:0] saturate(input int sum);
	if (sum > 32767)
		return {1'b1, 16'h7fff};
	if (sum < -32768)
		return {1'b1, 16'h8000};
	return {1'b0, sum[15:0]};
endfunction

// Runs the ROM image from address 0 until HLT
task automatic runModel();
	logic [15:0] w;
	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] addr;
	logic [16:0] alu;
	logic [3:0] op;
	logic [3:0] rd;
	logic n;
	logic v;
	logic z;
	logic take;
	int sa;
	int sb;
	int p;
	n = 1'b0;
	v = 1'b0;
	z = 1'b0;
	take = 1'b0;
	p = 0;
	haltAddr = -1;
	for (int i = 0; i < 16; i++)
		modelRegs[i] = '0;
	for (int i = 0; i < 256; i++)
		modelMem[i] = fillWord(8'(i));
	expQ.delete();
	while (haltAddr < 0 && p < 256) begin
		w = rom[p];
		op = w[15:12];
		rd = w[11:8];
		a = modelRegs[w[7:4]];
		b = modelRegs[w[3:0]];
		sa = $signed(a);
		sb = $signed(b);
		// Base register plus unsigned word offset
		addr = a + {12'h000, w[3:0]};
		p++;
		case (op)
			ADD, SUB, AND, XOR: begin
				if (op == ADD)
					alu = saturate(sa + sb);
				else if (op == SUB)
					alu = saturate(sa - sb);
				else if (op == AND)
					alu = {1'b0, a & b};
				else
					alu = {1'b0, a ^ b};
				v = alu[16];
				n = alu[15];
				z = (alu[15:0] == 16'h0000);
				modelRegs[rd] = alu[15:0];
			end
			LLB:
				modelRegs[rd] = {8'h00, w[7:0]};
			LHB:
				modelRegs[rd] = {w[7:0], modelRegs[rd][7:0]};
			LW: begin
				expQ.push_back('{addr, 16'h0000, 1'b0});
				modelRegs[rd] = modelMem[addr[7:0]];
			end
			SW: begin
				expQ.push_back('{addr, modelRegs[rd], 1'b1});
				modelMem[addr[7:0]] = modelRegs[rd];
			end
			B: begin
				case (w[11:9])
					NE: take = !z;
					EQ: take = z;
					GT: take = !z && !n;
					LT: take = n;
					GE: take = z || !n;
					LE: take = n || z;
					OV: take = v;
					default: take = 1'b1;
				endcase
				// Offset counts words from the next address
				if (take)
					p = p + int'($signed(w[8:0]));
			end
			HLT:
				haltAddr = p - 1;
			default: begin
			end
		endcase
		// r0 reads zero whatever was written
		modelRegs[0] = '0;
	end
endtask

`endif

//--- bench/cpuTb.sv
`timescale 1ns/1ns
`default_nettype none

module cpuTb;
	import cpuPkg::*;

	// Memory responder phases
	typedef enum logic [1:0] {
		rspIdle,
		rspWait,
		rspHold,
		rspDrop
	} rspStateE;

	logic clk = 1'b0;
	logic arstN = 1'b0;
	logic [dataW-1:0] pc;
	logic [dataW-1:0] instrWord;
	logic memReq;
	memCmdT memCmd;
	logic memAck = 1'b0;
	logic [dataW-1:0] memRdata = '0;
	logic hlt;

	// Program image with HLT in unused slots
	logic [15:0] rom [256];
	int progLen = 0;
	logic [15:0] dataMem [256];
	rspStateE rspState = rspIdle;
	logic [2:0] rspDelay = '0;
	int accessIdx = 0;
	int valueErrors = 0;
	int otherErrors = 0;
	int cycleCount = 0;
	int cycleLimit = 100000;
	logic [31:0] lfsr = 32'hb6642973;
	// Pool for random instructions
	opcodeE randOps [9] = '{ADD, SUB, AND, XOR, LLB, LHB, LW, SW, B};

	`include "isaModel.svh"

	cpu dut0 (
		.clk(clk),
		.arstN(arstN),
		.pc(pc),
		.instr(instrWord),
		.memReq(memReq),
		.memCmd(memCmd),
		.memAck(memAck),
		.memRdata(memRdata),
		.hlt(hlt)
	);

	// Instruction memory answers pc in the same cycle
	assign instrWord = rom[pc[7:0]];

	initial begin
		forever #20 clk = ~clk;
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic nextBit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] randBits(input int count);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < count; i++)
			r = {r[30:0], nextBit()};
		return r;
	endfunction

	function automatic logic [15:0] rWord(input opcodeE op, input logic [3:0] rd,
		input logic [3:0] rs, input logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic logic [15:0] immWord(input opcodeE op, input logic [3:0] rd,
		input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic logic [15:0] branchWord(input logic [2:0] cond, input logic [8:0] off);
		return {B, cond, off};
	endfunction

	task automatic emit(input logic [15:0] w);
		rom[progLen] = w;
		progLen++;
	endtask

	task automatic buildProgram();
		int randEnd;
		int room;
		opcodeE pick;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
		logic [8:0] off;
		for (int i = 0; i < 256; i++)
			rom[i] = immWord(HLT, 4'h0, 8'(i));
		progLen = 0;
		// r1 = 7fff, r2 = 1, then a saturating ADD and an OV skip
		emit(immWord(LLB, 4'd1, 8'hff));
		emit(immWord(LHB, 4'd1, 8'h7f));
		emit(immWord(LLB, 4'd2, 8'h01));
		emit(rWord(ADD, 4'd3, 4'd1, 4'd2));
		emit(branchWord(OV, 9'd1));
		emit(rWord(SW, 4'd3, 4'd0, 4'd0));
		// Negative saturation, then load-use and write-through paths
		emit(immWord(LHB, 4'd4, 8'h80));
		emit(rWord(SUB, 4'd5, 4'd4, 4'd2));
		emit(rWord(SW, 4'd5, 4'd0, 4'd1));
		emit(rWord(LW, 4'd6, 4'd0, 4'd1));
		emit(rWord(XOR, 4'd7, 4'd6, 4'd5));
		emit(rWord(ADD, 4'd8, 4'd6, 4'd2));
		emit(rWord(SW, 4'd8, 4'd7, 4'd2));
		emit(rWord(LW, 4'd9, 4'd2, 4'd4));
		emit(rWord(SW, 4'd9, 4'd9, 4'd0));
		emit(rWord(AND, 4'd10, 4'd1, 4'd4));
		// Each condition against zero, negative and overflowed flags
		for (int c = 0; c < 8; c++) begin
			for (int s = 0; s < 3; s++) begin
				case (s)
					0: emit(rWord(XOR, 4'd10, 4'd10, 4'd10));
					1: emit(rWord(AND, 4'd11, 4'd4, 4'd4));
					default: emit(rWord(ADD, 4'd12, 4'd1, 4'd1));
				endcase
				emit(branchWord(3'(c), 9'd1));
				// Present only on the not-taken path
				emit(rWord(SW, 4'd1, 4'd0, 4'(3 * c + s)));
			end
		end
		randEnd = progLen + 48;
		while (progLen < randEnd) begin
			pick = randOps[randBits(4) % 9];
			rd = 4'(randBits(4));
			rs = 4'(randBits(4));
			rt = 4'(randBits(4));
			if (pick == B) begin
				// Forward only and never past the register dump
				room = randEnd - progLen - 1;
				off = 9'(randBits(2));
				if (off > room)
					off = 9'(room);
				emit(branchWord(3'(randBits(3)), off));
			end else if (pick == LLB || pick == LHB) begin
				emit(immWord(pick, rd, 8'(randBits(8))));
			end else begin
				emit(rWord(pick, rd, rs, rt));
			end
		end
		// Dump r1..r15 to mem[1..15]
		for (int r = 1; r < 16; r++)
			emit(rWord(SW, 4'(r), 4'd0, 4'(r)));
		emit(immWord(HLT, 4'h0, 8'h00));
	endtask

	task automatic expectEq(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		assert (actual === expected)
		else begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			valueErrors++;
		end
	endtask

	// Bus against the next model access as memAck goes up
	task automatic compareAccess();
		memCmdT want;
		if (accessIdx >= expQ.size()) begin
			$display("Memory access %0d to address %h is not in the model's sequence",
				accessIdx, memCmd.addr);
			otherErrors++;
		end else begin
			want = expQ[accessIdx];
			expectEq($sformatf("access %0d addr", accessIdx), want.addr, memCmd.addr);
			expectEq($sformatf("access %0d write", accessIdx), 16'(want.write),
				16'(memCmd.write));
			if (want.write)
				expectEq($sformatf("access %0d wdata", accessIdx), want.wdata, memCmd.wdata);
		end
		accessIdx++;
	endtask

	// Four-phase responder with random ack delays
	always @(posedge clk) begin
		if (!arstN) begin
			rspState <= rspIdle;
			memAck <= 1'b0;
			for (int i = 0; i < 256; i++)
				dataMem[i] <= fillWord(8'(i));
		end else begin
			case (rspState)
				rspIdle:
					if (memReq && !memAck) begin
						rspDelay <= 3'(randBits(3));
						rspState <= rspWait;
					end
				rspWait:
					if (rspDelay == 0) begin
						compareAccess();
						memRdata <= dataMem[memCmd.addr[7:0]];
						if (memCmd.write)
							dataMem[memCmd.addr[7:0]] <= memCmd.wdata;
						memAck <= 1'b1;
						rspState <= rspHold;
					end else begin
						rspDelay <= rspDelay - 3'd1;
					end
				rspHold:
					// Ack stays up until the request is gone
					if (!memReq) begin
						rspDelay <= 3'(randBits(2));
						rspState <= rspDrop;
					end
				default:
					if (rspDelay == 0) begin
						memAck <= 1'b0;
						rspState <= rspIdle;
					end else begin
						rspDelay <= rspDelay - 3'd1;
					end
			endcase
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: the core did not halt within %0d cycles", cycleLimit);
			$display("Errors: value %0d, other %0d, protocol %0d",
				valueErrors, otherErrors, dut0.chk0.failCount);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		buildProgram();
		runModel();
		// Twice the cost of every instruction taken as a worst case memory op
		cycleLimit = progLen * (8 + 4 + 3) * 2;
		repeat (2) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		expectEq("reset pc", 16'h0000, pc);
		expectEq("reset hlt", 16'h0000, 16'(hlt));
		expectEq("reset memReq", 16'h0000, 16'(memReq));
		while (hlt !== 1'b1)
			@(negedge clk);
		expectEq("accesses before halt", 16'(expQ.size()), 16'(accessIdx));
		expectEq("halt pc", 16'(haltAddr + 1), pc);
		// Frozen pc and a quiet bus
		repeat (8) begin
			@(negedge clk);
			expectEq("pc after halt", 16'(haltAddr + 1), pc);
			expectEq("memReq after halt", 16'h0000, 16'(memReq));
		end
		$display("Errors: value %0d, other %0d, protocol %0d",
			valueErrors, otherErrors, dut0.chk0.failCount);
		if (valueErrors == 0 && otherErrors == 0 && dut0.chk0.failCount == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/cpu_chk.sv
`timescale 1ns/1ns
`default_nettype none

module cpuChk (
	input wire logic clk,
	input wire logic arstN,
	input wire logic [cpuPkg::dataW-1:0] pc,
	input wire logic memReq,
	input wire cpuPkg::memCmdT memCmd,
	input wire logic memAck,
	input wire logic hlt
);
	// Tally of failed properties
	int failCount = 0;

	// New request only after the old ack has dropped
	reqAfterAckLow: assert property (@(posedge clk) disable iff (!arstN)
		$rose(memReq) |-> !memAck)
	else begin
		$error("memReq rose while memAck was still high");
		failCount++;
	end

	// Command held for the whole request
	cmdStable: assert property (@(posedge clk) disable iff (!arstN)
		memReq && $past(memReq) |-> $stable(memCmd))
	else begin
		$error("memCmd changed while memReq was high");
		failCount++;
	end

	// Release one cycle after the ack is seen
	reqDropsAfterAck: assert property (@(posedge clk) disable iff (!arstN)
		memReq && memAck |=> !memReq)
	else begin
		$error("memReq stayed high after memAck was sampled");
		failCount++;
	end

	// Halt is sticky, freezes pc and silences the bus
	hltSticky: assert property (@(posedge clk) disable iff (!arstN)
		hlt |=> hlt && $stable(pc))
	else begin
		$error("hlt fell or pc moved after halt");
		failCount++;
	end

	noReqAfterHlt: assert property (@(posedge clk) disable iff (!arstN)
		hlt |-> !memReq)
	else begin
		$error("memReq high after hlt");
		failCount++;
	end

endmodule

bind cpu cpuChk chk0 (
	.clk(clk),
	.arstN(arstN),
	.pc(pc),
	.memReq(memReq),
	.memCmd(memCmd),
	.memAck(memAck),
	.hlt(hlt)
);

`default_nettype wire

//--- rtl/cpu.sv
`timescale 1ns/1ns
`default_nettype none

module cpu (
	input wire logic clk,
	input wire logic arstN,
	output logic [cpuPkg::dataW-1:0] pc,
	input wire cpuPkg::instrU instr,
	output logic memReq,
	output cpuPkg::memCmdT memCmd,
	input wire logic memAck,
	input wire logic [cpuPkg::dataW-1:0] memRdata,
	output logic hlt
);
	import cpuPkg::*;

	// Stage to stage
	decExT decEx;
	exResT exRes;
	wbT wb;

	// Register file read ports
	logic [regAddrW-1:0] rsIdx;
	logic [regAddrW-1:0] rtIdx;
	logic [dataW-1:0] rsData;
	logic [dataW-1:0] rtData;

	// Flush and stall network
	logic redirect;
	logic [dataW-1:0] redirectPc;
	logic stall;
	logic halted;

	decodeStage decode0 (
		.clk(clk),
		.arstN(arstN),
		.stall(stall),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.halted(halted),
		.instr(instr),
		.pc(pc),
		.rsIdx(rsIdx),
		.rtIdx(rtIdx),
		.rsData(rsData),
		.rtData(rtData),
		.decEx(decEx)
	);

	registerFile regFile0 (
		.clk(clk),
		.arstN(arstN),
		.rsIdx(rsIdx),
		.rtIdx(rtIdx),
		.wb(wb),
		.rsData(rsData),
		.rtData(rtData)
	);

	executeStage execute0 (
		.clk(clk),
		.arstN(arstN),
		.stall(stall),
		.decEx(decEx),
		.wb(wb),
		.exRes(exRes),
		.redirect(redirect),
		.redirectPc(redirectPc)
	);

	resultStage result0 (
		.clk(clk),
		.arstN(arstN),
		.exRes(exRes),
		.memReq(memReq),
		.memCmd(memCmd),
		.memAck(memAck),
		.memRdata(memRdata),
		.wb(wb),
		.stall(stall),
		.halted(halted),
		.hlt(hlt)
	);

endmodule

`default_nettype wire

//--- rtl/resultStage.sv
`timescale 1ns/1ns
`default_nettype none

module resultStage (
	input wire logic clk,
	input wire logic arstN,
	input wire cpuPkg::exResT exRes,
	output logic memReq,
	output cpuPkg::memCmdT memCmd,
	input wire logic memAck,
	input wire logic [cpuPkg::dataW-1:0] memRdata,
	output cpuPkg::wbT wb,
	output logic stall,
	output logic halted,
	output logic hlt
);
	import cpuPkg::*;

	// Four-phase master
	typedef enum logic [1:0] {
		stIdle,
		stReq,
		stRelease
	} stateE;

	stateE state;
	stateE stateNext;
	logic memOp;
	logic retire;
	logic aluWrite;
	logic haltReg;

	assign memOp = exRes.valid && (exRes.memRead || exRes.memWrite);
	// Ack seen while requesting ends the access
	assign retire = (state == stReq) && memAck;
	assign memReq = (state == stReq);
	assign stall = memOp && !retire;

	// Command follows the held entry
	always_comb begin
		memCmd.addr = exRes.aluOut;
		memCmd.wdata = exRes.storeData;
		memCmd.write = exRes.memWrite;
	end

	always_comb begin
		stateNext = state;
		case (state)
			stIdle:
				// Wait for the previous ack to clear
				if (memOp && !memAck && !haltReg)
					stateNext = stReq;
			stReq:
				if (memAck)
					stateNext = stRelease;
			stRelease:
				if (!memAck)
					stateNext = (memOp && !haltReg) ? stReq : stIdle;
			default:
				stateNext = stIdle;
		endcase
	end

	// ALU results land on arrival, loads at retirement
	assign aluWrite = exRes.valid && exRes.regWrite && !exRes.memRead;

	always_comb begin
		wb.en = aluWrite || (retire && exRes.memRead);
		wb.rd = exRes.rd;
		wb.data = exRes.memRead ? memRdata : exRes.aluOut;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= stIdle;
			haltReg <= 1'b0;
		end else begin
			state <= stateNext;
			// Sticky until reset
			if (exRes.valid && exRes.isHalt)
				haltReg <= 1'b1;
		end
	end

	assign halted = haltReg;
	assign hlt = haltReg;

endmodule

`default_nettype wire

//--- rtl/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage (
	input wire logic clk,
	input wire logic arstN,
	input wire logic stall,
	input wire cpuPkg::decExT decEx,
	input wire cpuPkg::wbT wb,
	output cpuPkg::exResT exRes,
	output logic redirect,
	output logic [cpuPkg::dataW-1:0] redirectPc
);
	import cpuPkg::*;

	flagsT flags;
	flagsT aluFlags;
	opcodeE op;
	logic [dataW-1:0] opA;
	logic [dataW-1:0] opB;
	logic [dataW-1:0] aluOut;
	// One extra bit to catch signed overflow
	logic [dataW:0] wide;
	logic setFlags;
	logic taken;
	logic [dataW-1:0] brOffset;
	exResT nextRes;

	assign op = decEx.instr.rType.opcode;

	// Result stage write beats the captured register value
	assign opA = (wb.en && wb.rd != '0 && wb.rd == decEx.rsIdx) ? wb.data : decEx.srcA;
	assign opB = (wb.en && wb.rd != '0 && wb.rd == decEx.rtIdx) ? wb.data : decEx.srcB;

	always_comb begin
		wide = '0;
		aluOut = '0;
		setFlags = 1'b0;
		aluFlags = flags;
		case (op)
			ADD, SUB: begin
				if (op == ADD)
					wide = {opA[dataW-1], opA} + {opB[dataW-1], opB};
				else
					wide = {opA[dataW-1], opA} - {opB[dataW-1], opB};
				setFlags = 1'b1;
				// Sign bits disagree means overflow, clamp to range
				if (wide[dataW] != wide[dataW-1]) begin
					aluOut = wide[dataW] ? 16'h8000 : 16'h7fff;
					aluFlags.v = 1'b1;
				end else begin
					aluOut = wide[dataW-1:0];
					aluFlags.v = 1'b0;
				end
			end
			AND: begin
				aluOut = opA & opB;
				setFlags = 1'b1;
				aluFlags.v = 1'b0;
			end
			XOR: begin
				aluOut = opA ^ opB;
				setFlags = 1'b1;
				aluFlags.v = 1'b0;
			end
			LW, SW:
				// Base plus unsigned word offset
				aluOut = opA + {12'b0, decEx.instr.rType.rt};
			LLB:
				aluOut = {8'h00, decEx.instr.immType.imm8};
			LHB:
				aluOut = {decEx.instr.immType.imm8, opB[7:0]};
			default: begin
			end
		endcase
		aluFlags.n = aluOut[dataW-1];
		aluFlags.z = (aluOut == '0);
	end

	// Condition check against the committed flags
	always_comb begin
		taken = 1'b0;
		case (decEx.instr.brType.cond)
			NE: taken = !flags.z;
			EQ: taken = flags.z;
			GT: taken = !flags.z && !flags.n;
			LT: taken = flags.n;
			GE: taken = flags.z || !flags.n;
			LE: taken = flags.n || flags.z;
			OV: taken = flags.v;
			UN: taken = 1'b1;
		endcase
	end

	assign brOffset = {{(dataW-9){decEx.instr.brType.offset[8]}}, decEx.instr.brType.offset};
	assign redirectPc = decEx.pcNext + brOffset;
	// Held branch waits out the stall before redirecting
	assign redirect = decEx.valid && decEx.isBranch && taken && !stall;

	always_comb begin
		nextRes.valid = decEx.valid;
		nextRes.aluOut = aluOut;
		nextRes.storeData = opB;
		nextRes.rd = decEx.instr.rType.rd;
		nextRes.regWrite = decEx.regWrite;
		nextRes.memRead = decEx.memRead;
		nextRes.memWrite = decEx.memWrite;
		nextRes.isHalt = decEx.isHalt;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			flags <= '0;
			exRes <= '0;
		end else if (!stall) begin
			if (decEx.valid && setFlags)
				flags <= aluFlags;
			exRes <= nextRes;
		end
	end

endmodule

`default_nettype wire

//--- rtl/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
	input wire logic clk,
	input wire logic arstN,
	input wire logic stall,
	input wire logic redirect,
	input wire logic [cpuPkg::dataW-1:0] redirectPc,
	input wire logic halted,
	input wire cpuPkg::instrU instr,
	output logic [cpuPkg::dataW-1:0] pc,
	output logic [cpuPkg::regAddrW-1:0] rsIdx,
	output logic [cpuPkg::regAddrW-1:0] rtIdx,
	input wire logic [cpuPkg::dataW-1:0] rsData,
	input wire logic [cpuPkg::dataW-1:0] rtData,
	output cpuPkg::decExT decEx
);
	import cpuPkg::*;

	logic [dataW-1:0] pcReg;
	// Set once HLT is decoded, fetch stops right behind it
	logic fetchStop;
	opcodeE op;
	decExT nextEntry;

	assign pc = pcReg;
	assign op = instr.rType.opcode;

	// Source register selection per instruction view
	always_comb begin
		rsIdx = '0;
		rtIdx = '0;
		case (op)
			ADD, SUB, AND, XOR: begin
				rsIdx = instr.rType.rs;
				rtIdx = instr.rType.rt;
			end
			LW:
				rsIdx = instr.rType.rs;
			SW: begin
				// Store data comes from the rd field
				rsIdx = instr.rType.rs;
				rtIdx = instr.rType.rd;
			end
			LHB:
				// Low byte of rd survives
				rtIdx = instr.immType.rd;
			default: begin
			end
		endcase
	end

	// Control decode and operand capture
	always_comb begin
		nextEntry = '0;
		nextEntry.valid = 1'b1;
		nextEntry.instr = instr;
		nextEntry.pcNext = pcReg + 16'd1;
		nextEntry.srcA = rsData;
		nextEntry.srcB = rtData;
		nextEntry.rsIdx = rsIdx;
		nextEntry.rtIdx = rtIdx;
		nextEntry.regWrite = op inside {ADD, SUB, AND, XOR, LW, LLB, LHB};
		nextEntry.memRead = (op == LW);
		nextEntry.memWrite = (op == SW);
		nextEntry.isBranch = (op == B);
		nextEntry.isHalt = (op == HLT);
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pcReg <= '0;
			fetchStop <= 1'b0;
			decEx <= '0;
		end else if (!stall) begin
			if (redirect) begin
				// Squash the wrong-path fetch
				pcReg <= redirectPc;
				decEx.valid <= 1'b0;
			end else if (!halted && !fetchStop) begin
				pcReg <= nextEntry.pcNext;
				decEx <= nextEntry;
				fetchStop <= nextEntry.isHalt;
			end else begin
				// pc frozen one past HLT
				decEx.valid <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile (
	input wire logic clk,
	input wire logic arstN,
	input wire logic [cpuPkg::regAddrW-1:0] rsIdx,
	input wire logic [cpuPkg::regAddrW-1:0] rtIdx,
	input wire cpuPkg::wbT wb,
	output logic [cpuPkg::dataW-1:0] rsData,
	output logic [cpuPkg::dataW-1:0] rtData
);
	import cpuPkg::*;

	// r0 has no storage
	logic [dataW-1:0] regs [1:regCount-1];

	// Zero for r0, then write-through, then storage
	function automatic logic [dataW-1:0] readPort(input logic [regAddrW-1:0] idx);
		if (idx == '0)
			return '0;
		if (wb.en && wb.rd == idx)
			return wb.data;
		return regs[idx];
	endfunction

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < regCount; i++)
				regs[i] <= '0;
		end else if (wb.en && wb.rd != '0) begin
			regs[wb.rd] <= wb.data;
		end
	end

	always_comb begin
		rsData = readPort(rsIdx);
		rtData = readPort(rtIdx);
	end

endmodule

`default_nettype wire

//--- rtl/cpuPkg.sv
`default_nettype none

package cpuPkg;

	// Datapath widths
	localparam int dataW = 16;
	localparam int regAddrW = 4;
	localparam int regCount = 1 << regAddrW;

	// Opcode map keeps the WISC slots for the ops we kept
	typedef enum logic [3:0] {
		ADD = 4'h0,
		SUB = 4'h1,
		XOR = 4'h2,
		AND = 4'h3,
		LW  = 4'h8,
		SW  = 4'h9,
		LHB = 4'ha,
		LLB = 4'hb,
		B   = 4'hc,
		HLT = 4'hf
	} opcodeE;

	// Register form, also used by LW and SW
	// LW:  rd = dest, rs = base, rt = unsigned word offset
	// SW:  rd = data source, rs = base, rt = unsigned word offset
	typedef struct packed {
		opcodeE opcode;
		logic [regAddrW-1:0] rd;
		logic [regAddrW-1:0] rs;
		logic [regAddrW-1:0] rt;
	} rTypeT;

	// LLB and LHB
	typedef struct packed {
		opcodeE opcode;
		logic [regAddrW-1:0] rd;
		logic [7:0] imm8;
	} immTypeT;

	// Branch, offset counted in words from the next pc
	typedef struct packed {
		opcodeE opcode;
		logic [2:0] cond;
		logic signed [8:0] offset;
	} brTypeT;

	typedef union packed {
		rTypeT rType;
		immTypeT immType;
		brTypeT brType;
	} instrU;

	typedef struct packed {
		logic n;
		logic v;
		logic z;
	} flagsT;

	// Decode to execute
	typedef struct packed {
		logic valid;
		instrU instr;
		logic [dataW-1:0] pcNext;
		logic [dataW-1:0] srcA;
		logic [dataW-1:0] srcB;
		logic [regAddrW-1:0] rsIdx;
		logic [regAddrW-1:0] rtIdx;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic isBranch;
		logic isHalt;
	} decExT;

	// Execute to result
	typedef struct packed {
		logic valid;
		logic [dataW-1:0] aluOut;
		logic [dataW-1:0] storeData;
		logic [regAddrW-1:0] rd;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic isHalt;
	} exResT;

	typedef struct packed {
		logic [dataW-1:0] addr;
		logic [dataW-1:0] wdata;
		logic write;
	} memCmdT;

	// Writeback, seen by register file and forwarding
	typedef struct packed {
		logic en;
		logic [regAddrW-1:0] rd;
		logic [dataW-1:0] data;
	} wbT;

	// Branch condition codes
	localparam logic [2:0] NE = 3'b000;
	localparam logic [2:0] EQ = 3'b001;
	localparam logic [2:0] GT = 3'b010;
	localparam logic [2:0] LT = 3'b011;
	localparam logic [2:0] GE = 3'b100;
	localparam logic [2:0] LE = 3'b101;
	localparam logic [2:0] OV = 3'b110;
	localparam logic [2:0] UN = 3'b111;

endpackage

`default_nettype wire
